// ==== common/dqmConfigPkg.sv ====
`default_nettype none

package dqmConfigPkg;

    localparam int ADDR_BITS = 8;
    localparam int DATA_BITS = 32;

    // register map
    localparam logic [ADDR_BITS-1:0] CTRL_ADDR    = 8'h00;
    localparam logic [ADDR_BITS-1:0] MEAN_ADDR    = 8'h01;
    localparam logic [ADDR_BITS-1:0] BITTIME_ADDR = 8'h02;
    localparam logic [ADDR_BITS-1:0] STATUS_ADDR  = 8'h03;

    // the 64 LUT words sit at 0x40 to 0x7F, selected by the top two address bits
    localparam logic [ADDR_BITS-1:0] LUT_BASE     = 8'h40;
    localparam logic [ADDR_BITS-1:0] LUT_MASK     = 8'hC0;

    typedef struct packed {
        logic [1:0]  reserved1;
        logic [13:0] payloadSize;
        logic [11:0] reserved0;
        logic [3:0]  avgLog2;
    } ctrlView_t;

    typedef struct packed {
        logic [15:0] reserved;
        logic [15:0] dqmValue;
    } lutView_t;

    // one bus word, seen either as the control register or as a LUT entry
    typedef union packed {
        ctrlView_t            ctrl;
        lutView_t             lut;
        logic [DATA_BITS-1:0] word;
    } dqmRegWord_u;

endpackage

`default_nettype wire

// ==== common/dqmFramePkg.sv ====
`default_nettype none

package dqmFramePkg;

    // every frame opens with this word so the receiver can lock on
    localparam logic [15:0] SYNC_WORD = 16'hFAF3;

    // sync word followed by the DQM value
    localparam int HEADER_BITS = 32;

    localparam int DQM_BITS = 16;

    // log index width, which is also the LUT address width
    localparam int LOG_BITS = 6;

    localparam int MAG_BITS = 13;

endpackage

`default_nettype wire

// ==== common/dqmBusIf.sv ====
`default_nettype none

interface dqmBusIf;

    import dqmConfigPkg::*;

    logic                 cs;
    logic                 wr;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] wdata;
    logic [DATA_BITS-1:0] rdata;

    modport master (
        output cs, wr, addr, wdata,
        input  rdata
    );

    // only the register block drives rdata, the LUT hands its word over a side port
    modport slave (
        input  cs, wr, addr, wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== common/dqmEstimateIf.sv ====
`default_nettype none

interface dqmEstimateIf #(
    parameter int SUM_BITS = 34
);

    import dqmFramePkg::*;

    logic                req;
    logic                ack;
    logic [SUM_BITS-1:0] mseSum;
    logic [LOG_BITS-1:0] logIndex;

    // four-phase handshake, data is held by the source while req is high
    modport source (
        output req, mseSum, logIndex,
        input  ack
    );

    modport sink (
        input  req, mseSum, logIndex,
        output ack
    );

endinterface

`default_nettype wire

// ==== logic/dqmRegs.sv ====
`default_nettype none

module dqmRegs (
    input  wire logic                               clk,
    input  wire logic                               rstN,
    dqmBusIf.slave                                  bus,
    output logic [3:0]                              avgLog2,
    output logic [13:0]                             payloadSize,
    output logic [dqmFramePkg::MAG_BITS-1:0]        meanMag,
    output logic [15:0]                             clksPerBit,
    input  wire logic [dqmConfigPkg::DATA_BITS-1:0] lutRdata,
    input  wire logic [dqmFramePkg::LOG_BITS-1:0]   logIndex,
    input  wire logic [7:0]                         droppedCount
);

    import dqmConfigPkg::*;

    dqmRegWord_u          wrWord;
    dqmRegWord_u          ctrlWord;
    logic [DATA_BITS-1:0] readWord;

    assign wrWord = dqmRegWord_u'(bus.wdata);

    // ========================================
    // configuration writes
    // ========================================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            avgLog2     <= '0;
            payloadSize <= '0;
            meanMag     <= '0;
            clksPerBit  <= 16'd4;
        end else if (bus.cs && bus.wr) begin
            case (bus.addr)
                CTRL_ADDR: begin
                    avgLog2     <= wrWord.ctrl.avgLog2;
                    payloadSize <= wrWord.ctrl.payloadSize;
                end
                MEAN_ADDR:    meanMag    <= bus.wdata[$bits(meanMag)-1:0];
                BITTIME_ADDR: clksPerBit <= bus.wdata[15:0];
                default:      ;
            endcase
        end
    end

    // ========================================
    // read-back
    // ========================================
    always_comb begin
        ctrlWord                  = '0;
        ctrlWord.ctrl.avgLog2     = avgLog2;
        ctrlWord.ctrl.payloadSize = payloadSize;
        if ((bus.addr & LUT_MASK) == LUT_BASE) begin
            readWord = lutRdata;
        end else begin
            case (bus.addr)
                CTRL_ADDR:    readWord = ctrlWord.word;
                MEAN_ADDR:    readWord = DATA_BITS'(meanMag);
                BITTIME_ADDR: readWord = DATA_BITS'(clksPerBit);
                // dropped count in 15:8, last log index in 5:0
                STATUS_ADDR:  readWord = DATA_BITS'({droppedCount, 2'b00, logIndex});
                default:      readWord = '0;
            endcase
        end
    end

    // rdata holds the last word read until the next read cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            bus.rdata <= '0;
        end else if (bus.cs && !bus.wr) begin
            bus.rdata <= readWord;
        end
    end

endmodule

`default_nettype wire

// ==== mseEstimate/mseEstimate.sv ====
`default_nettype none

module mseEstimate #(
    parameter int SUM_BITS = 34
) (
    input  wire logic                             clk,
    input  wire logic                             rstN,
    input  wire logic                             magClkEn,
    input  wire logic [dqmFramePkg::MAG_BITS-1:0] mag,
    input  wire logic [dqmFramePkg::MAG_BITS-1:0] meanMag,
    input  wire logic [3:0]                       avgLog2,
    dqmEstimateIf.source                          est,
    output logic [7:0]                            droppedCount,
    output logic [SUM_BITS-1:0]                   mseSum,
    output logic [dqmFramePkg::LOG_BITS-1:0]      logIndex
);

    import dqmFramePkg::*;

    logic signed [MAG_BITS:0] diff;
    logic [MAG_BITS-1:0]      absDiff;
    logic [2*MAG_BITS-1:0]    square;
    logic [SUM_BITS-1:0]      acc;
    logic [SUM_BITS-1:0]      blockSum;
    logic [SUM_BITS-1:0]      blockMean;
    logic [15:0]              sampleCount;
    logic                     blockLast;
    logic                     doneD1;
    logic                     doneD2;
    logic                     req;
    logic [7:0]               lead;
    logic [SUM_BITS+1:0]      shifted;
    logic [LOG_BITS-1:0]      logNext;

    // ========================================
    // squared error accumulation
    // ========================================
    always_comb begin
        diff    = $signed({1'b0, mag}) - $signed({1'b0, meanMag});
        absDiff = diff[MAG_BITS] ? MAG_BITS'(-diff) : diff[MAG_BITS-1:0];
        square  = absDiff * absDiff;
    end

    assign blockLast = sampleCount == ((16'd1 << avgLog2) - 16'd1);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            acc         <= '0;
            sampleCount <= '0;
            doneD1      <= 1'b0;
            doneD2      <= 1'b0;
        end else begin
            doneD1 <= magClkEn && blockLast;
            doneD2 <= doneD1;
            if (magClkEn) begin
                if (blockLast) begin
                    acc         <= '0;
                    sampleCount <= '0;
                end else begin
                    acc         <= acc + SUM_BITS'(square);
                    sampleCount <= sampleCount + 16'd1;
                end
            end
        end
    end

    // block total, then the mean one cycle later
    always_ff @(posedge clk) begin
        if (magClkEn && blockLast) begin
            blockSum <= acc + SUM_BITS'(square);
        end
        if (doneD1) begin
            blockMean <= blockSum >> avgLog2;
        end
    end

    // ========================================
    // log2 index with two fraction bits
    // ========================================
    always_comb begin
        lead = '0;
        for (int i = 0; i < SUM_BITS; i++) begin
            if (blockMean[i]) begin
                lead = 8'(i);
            end
        end
        // the two bits just below the leading one land in bits 1:0
        shifted = {blockMean, 2'b00} >> lead;
        if (lead > 8'd15) begin
            logNext = '1;
        end else begin
            logNext = {lead[3:0], shifted[1:0]};
        end
    end

    // a result that finds the handshake still open is dropped and counted
    always_ff @(posedge clk) begin
        if (!rstN) begin
            req          <= 1'b0;
            mseSum       <= '0;
            logIndex     <= '0;
            droppedCount <= '0;
        end else begin
            if (req && est.ack) begin
                req <= 1'b0;
            end
            if (doneD2) begin
                if (!req && !est.ack) begin
                    req      <= 1'b1;
                    mseSum   <= blockMean;
                    logIndex <= logNext;
                end else begin
                    droppedCount <= droppedCount + 8'd1;
                end
            end
        end
    end

    assign est.req      = req;
    assign est.mseSum   = mseSum;
    assign est.logIndex = logIndex;

endmodule

`default_nettype wire

// ==== logic/dqmLookupTable.sv ====
`default_nettype none

module dqmLookupTable (
    input  wire logic                          clk,
    input  wire logic                          rstN,
    dqmBusIf.slave                             bus,
    output logic [dqmConfigPkg::DATA_BITS-1:0] lutRdata,
    dqmEstimateIf.sink                         est,
    output logic                               dqmReq,
    input  wire logic                          dqmAck,
    output logic [dqmFramePkg::DQM_BITS-1:0]   dqmValue
);

    import dqmConfigPkg::*;
    import dqmFramePkg::*;

    logic [DQM_BITS-1:0] lutMem [2**LOG_BITS];
    dqmRegWord_u         wrWord;
    dqmRegWord_u         rdWord;
    logic                lutHit;
    logic                ack;
    logic                pending;

    assign lutHit = (bus.addr & LUT_MASK) == LUT_BASE;
    assign wrWord = dqmRegWord_u'(bus.wdata);

    always_ff @(posedge clk) begin
        if (bus.cs && bus.wr && lutHit) begin
            lutMem[bus.addr[LOG_BITS-1:0]] <= wrWord.lut.dqmValue;
        end
        // logIndex is still held by the estimator, its outputs only move on a new req
        if (pending) begin
            dqmValue <= lutMem[est.logIndex];
        end
    end

    always_comb begin
        rdWord              = '0;
        rdWord.lut.dqmValue = lutMem[bus.addr[LOG_BITS-1:0]];
    end

    assign lutRdata = rdWord.word;

    // a new estimate waits until the framer side is idle again
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ack     <= 1'b0;
            pending <= 1'b0;
            dqmReq  <= 1'b0;
        end else begin
            if (est.req && !ack && !pending && !dqmReq && !dqmAck) begin
                ack     <= 1'b1;
                pending <= 1'b1;
            end else if (!est.req) begin
                ack <= 1'b0;
            end
            if (pending) begin
                pending <= 1'b0;
                dqmReq  <= 1'b1;
            end else if (dqmReq && dqmAck) begin
                dqmReq <= 1'b0;
            end
        end
    end

    assign est.ack = ack;

endmodule

`default_nettype wire

// ==== dqmFramer/dqmFramer.sv ====
`default_nettype none

module dqmFramer #(
    parameter int FIFO_DEPTH = 64
) (
    input  wire logic                             clk,
    input  wire logic                             rstN,
    input  wire logic                             bitClkEn,
    input  wire logic                             payloadBit,
    input  wire logic [13:0]                      payloadSize,
    input  wire logic [15:0]                      clksPerBit,
    input  wire logic                             dqmReq,
    output logic                                  dqmAck,
    input  wire logic [dqmFramePkg::DQM_BITS-1:0] dqmValue,
    output logic                                  dqmStartOfFrame,
    output logic                                  dqmBitEn,
    output logic                                  dqmBit
);

    import dqmFramePkg::*;

    localparam int PTR_BITS = $clog2(FIFO_DEPTH);

    logic                   fifoMem [FIFO_DEPTH];
    logic [PTR_BITS:0]      wrPtr;
    logic [PTR_BITS:0]      rdPtr;
    logic                   fifoEmpty;
    logic                   fifoFull;
    logic                   push;
    logic                   pop;
    logic                   active;
    logic [15:0]            bitTimer;
    logic                   tick;
    logic [14:0]            bitCount;
    logic                   inHeader;
    logic                   lastBit;
    logic                   startFrame;
    logic [HEADER_BITS-1:0] header;
    logic                   nextBit;

    // ========================================
    // payload bit FIFO
    // ========================================
    assign fifoEmpty = wrPtr == rdPtr;
    assign fifoFull  = (wrPtr - rdPtr) == (PTR_BITS + 1)'(FIFO_DEPTH);
    assign push      = bitClkEn && !fifoFull;
    assign pop       = tick && !inHeader && !fifoEmpty;

    always_ff @(posedge clk) begin
        if (push) begin
            fifoMem[wrPtr[PTR_BITS-1:0]] <= payloadBit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    // ========================================
    // bit timer and serializer
    // ========================================
    assign tick       = active && (bitTimer == clksPerBit - 16'd1);
    assign inHeader   = bitCount < 15'(HEADER_BITS);
    assign lastBit    = bitCount == 15'(HEADER_BITS) + 15'(payloadSize) - 15'd1;
    // a waiting value may start right on the last bit of the running frame
    assign startFrame = dqmReq && !dqmAck && (!active || (tick && lastBit));
    assign nextBit    = inHeader ? header[HEADER_BITS-1]
                                 : (!fifoEmpty && fifoMem[rdPtr[PTR_BITS-1:0]]);

    always_ff @(posedge clk) begin
        if (startFrame) begin
            header <= {SYNC_WORD, dqmValue};
        end else if (tick) begin
            header <= header << 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            active          <= 1'b0;
            bitTimer        <= '0;
            bitCount        <= '0;
            dqmAck          <= 1'b0;
            dqmStartOfFrame <= 1'b0;
            dqmBitEn        <= 1'b0;
            dqmBit          <= 1'b0;
        end else begin
            dqmStartOfFrame <= startFrame;
            dqmBitEn        <= tick;
            if (tick) begin
                dqmBit <= nextBit;
            end
            if (startFrame) begin
                dqmAck <= 1'b1;
            end else if (!dqmReq) begin
                dqmAck <= 1'b0;
            end
            if (startFrame) begin
                active   <= 1'b1;
                bitTimer <= '0;
                bitCount <= '0;
            end else if (tick) begin
                bitTimer <= '0;
                if (lastBit) begin
                    active <= 1'b0;
                end else begin
                    bitCount <= bitCount + 15'd1;
                end
            end else if (active) begin
                bitTimer <= bitTimer + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/dqm.sv ====
`default_nettype none

module dqm #(
    parameter int SUM_BITS   = 34,
    parameter int FIFO_DEPTH = 64
) (
    input  wire logic                               clk,
    input  wire logic                               rstN,
    input  wire logic                               cs,
    input  wire logic                               wr,
    input  wire logic [dqmConfigPkg::ADDR_BITS-1:0] addr,
    input  wire logic [dqmConfigPkg::DATA_BITS-1:0] wdata,
    output logic [dqmConfigPkg::DATA_BITS-1:0]      rdata,
    input  wire logic                               magClkEn,
    input  wire logic [dqmFramePkg::MAG_BITS-1:0]   mag,
    input  wire logic                               bitClkEn,
    input  wire logic                               payloadBit,
    output logic                                    dqmStartOfFrame,
    output logic                                    dqmBitEn,
    output logic                                    dqmBit,
    output logic [SUM_BITS-1:0]                     mseSum,
    output logic [dqmFramePkg::LOG_BITS-1:0]        log10Mse
);

    import dqmConfigPkg::*;
    import dqmFramePkg::*;

    logic [3:0]           avgLog2;
    logic [13:0]          payloadSize;
    logic [MAG_BITS-1:0]  meanMag;
    logic [15:0]          clksPerBit;
    logic [DATA_BITS-1:0] lutRdata;
    logic [7:0]           droppedCount;
    logic                 dqmReq;
    logic                 dqmAck;
    logic [DQM_BITS-1:0]  dqmValue;

    dqmBusIf busIf ();
    dqmEstimateIf #(.SUM_BITS(SUM_BITS)) estIf ();

    assign busIf.cs    = cs;
    assign busIf.wr    = wr;
    assign busIf.addr  = addr;
    assign busIf.wdata = wdata;
    assign rdata       = busIf.rdata;

    // ========================================
    // input side
    // ========================================
    dqmRegs dqmr (
        .clk(clk),
        .rstN(rstN),
        .bus(busIf),
        .avgLog2(avgLog2),
        .payloadSize(payloadSize),
        .meanMag(meanMag),
        .clksPerBit(clksPerBit),
        .lutRdata(lutRdata),
        .logIndex(log10Mse),
        .droppedCount(droppedCount)
    );

    mseEstimate #(.SUM_BITS(SUM_BITS)) dqmm (
        .clk(clk),
        .rstN(rstN),
        .magClkEn(magClkEn),
        .mag(mag),
        .meanMag(meanMag),
        .avgLog2(avgLog2),
        .est(estIf),
        .droppedCount(droppedCount),
        .mseSum(mseSum),
        .logIndex(log10Mse)
    );

    // ========================================
    // lookup and framing
    // ========================================
    dqmLookupTable dqml (
        .clk(clk),
        .rstN(rstN),
        .bus(busIf),
        .lutRdata(lutRdata),
        .est(estIf),
        .dqmReq(dqmReq),
        .dqmAck(dqmAck),
        .dqmValue(dqmValue)
    );

    dqmFramer #(.FIFO_DEPTH(FIFO_DEPTH)) dqmf (
        .clk(clk),
        .rstN(rstN),
        .bitClkEn(bitClkEn),
        .payloadBit(payloadBit),
        .payloadSize(payloadSize),
        .clksPerBit(clksPerBit),
        .dqmReq(dqmReq),
        .dqmAck(dqmAck),
        .dqmValue(dqmValue),
        .dqmStartOfFrame(dqmStartOfFrame),
        .dqmBitEn(dqmBitEn),
        .dqmBit(dqmBit)
    );

endmodule

`default_nettype wire

// ==== bench/dqmTb.sv ====
`default_nettype none

module dqmTb;

    import dqmConfigPkg::*;
    import dqmFramePkg::*;

    localparam int WAIT_LIMIT = 20000;
    localparam int MEAN_VALUE = 4000;
    localparam int QUIET_CYCLES = 100;

    logic        clk;
    logic        rstN;
    logic        cs;
    logic        wr;
    logic [7:0]  addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        magClkEn;
    logic [12:0] mag;
    logic        bitClkEn;
    logic        payloadBit;
    logic        dqmStartOfFrame;
    logic        dqmBitEn;
    logic        dqmBit;
    logic [33:0] mseSum;
    logic [5:0]  log10Mse;

    logic [31:0] rng;
    logic [15:0] lutModel [64];
    int          sampleQ [$];
    logic        payloadQ [$];
    logic        expQ [$];
    logic [15:0] expDqm;
    logic        expBit;
    int          curCpb;
    int          curPayload;
    int          errors;
    int          checks;
    int          frameCount;
    int          bitIdx;
    longint      cycleCount;
    longint      lastBitCycle;

    dqm i_dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // block mean of the squared deviations, then four times the leading one position
    // plus the two bits below it
    function automatic void mseRef(input int mean, input int log2n,
                                   output logic [33:0] mse, output logic [5:0] idx);
        longint sum;
        int     lead;
        int     frac;
        sum = 0;
        foreach (sampleQ[i]) begin
            sum += longint'(sampleQ[i] - mean) * longint'(sampleQ[i] - mean);
        end
        mse  = 34'(sum >> log2n);
        lead = -1;
        frac = 0;
        for (int b = 0; b < 34; b++) begin
            if (mse[b]) lead = b;
        end
        if (lead >= 1 && mse[lead-1]) frac += 2;
        if (lead >= 2 && mse[lead-2]) frac += 1;
        if (lead < 0) begin
            idx = 6'd0;
        end else if (lead > 15) begin
            idx = 6'd63;
        end else begin
            idx = 6'(lead * 4 + frac);
        end
    endfunction

    // sync word, DQM value, then payload bits in arrival order, zeros once the FIFO is dry
    function automatic void frameRef(input logic [15:0] dqmVal, input int nPayload);
        logic [31:0] header;
        header = {SYNC_WORD, dqmVal};
        for (int i = 31; i >= 0; i--) begin
            expQ.push_back(header[i]);
        end
        for (int i = 0; i < nPayload; i++) begin
            if (payloadQ.size() > 0) begin
                expQ.push_back(payloadQ.pop_front());
            end else begin
                expQ.push_back(1'b0);
            end
        end
    endfunction

    task automatic reportMismatch(input string name, input longint expected,
                                  input longint actual);
        errors++;
        $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
    endtask

    task automatic abortRun(input string what);
        errors++;
        $display("%s", what);
        $display("%0d errors in %0d checks", errors, checks);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic busWrite(input logic [7:0] a, input logic [31:0] d);
        @(posedge clk);
        cs    <= 1'b1;
        wr    <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        cs <= 1'b0;
        wr <= 1'b0;
    endtask

    task automatic busRead(input logic [7:0] a, output logic [31:0] d);
        @(posedge clk);
        cs   <= 1'b1;
        wr   <= 1'b0;
        addr <= a;
        @(posedge clk);
        cs <= 1'b0;
        @(negedge clk);
        d = rdata;
    endtask

    task automatic pushPayload(input int n);
        logic b;
        for (int i = 0; i < n; i++) begin
            rng = xorshift32(rng);
            b   = rng[7];
            payloadQ.push_back(b);
            @(posedge clk);
            bitClkEn   <= 1'b1;
            payloadBit <= b;
        end
        @(posedge clk);
        bitClkEn <= 1'b0;
    endtask

    task automatic driveBlock(input int log2n, input int spread);
        int s;
        sampleQ.delete();
        for (int i = 0; i < (1 << log2n); i++) begin
            rng = xorshift32(rng);
            s   = MEAN_VALUE + int'(rng % 32'(2 * spread + 1)) - spread;
            sampleQ.push_back(s);
            @(posedge clk);
            magClkEn <= 1'b1;
            mag      <= 13'(s);
            @(posedge clk);
            magClkEn <= 1'b0;
        end
    endtask

    task automatic waitFrameStart();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!dqmStartOfFrame && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!dqmStartOfFrame) abortRun("timeout while waiting for a start of frame");
    endtask

    task automatic waitFrameEnd();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (expQ.size() != 0 && waited < WAIT_LIMIT);
        if (expQ.size() != 0) abortRun("timeout while frame bits were still missing");
    endtask

    task automatic waitQuiet();
        int waited;
        int idle;
        waited = 0;
        idle   = 0;
        while (idle < QUIET_CYCLES && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
            if (dqmBitEn || dqmStartOfFrame || expQ.size() != 0) begin
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (idle < QUIET_CYCLES) abortRun("timeout while waiting for the framer to go idle");
    endtask

    task automatic runFrameTest(input string name, input int log2n, input int size,
                                input int spread, input int nPush);
        logic [33:0] expMse;
        logic [5:0]  expIdx;
        logic [31:0] rd;
        busWrite(CTRL_ADDR, {2'b00, 14'(size), 12'h000, 4'(log2n)});
        curPayload = size;
        pushPayload(nPush);
        driveBlock(log2n, spread);
        mseRef(MEAN_VALUE, log2n, expMse, expIdx);
        expDqm = lutModel[expIdx];
        waitFrameStart();
        checks += 2;
        if (mseSum !== expMse) reportMismatch({name, " mseSum"}, expMse, mseSum);
        if (log10Mse !== expIdx) reportMismatch({name, " log10Mse"}, expIdx, log10Mse);
        waitFrameEnd();
        // the status word keeps the index of the last estimate that was accepted
        busRead(STATUS_ADDR, rd);
        checks++;
        if (rd[5:0] !== expIdx) reportMismatch({name, " status log index"}, expIdx, rd[5:0]);
    endtask

    // ========================================
    // frame bit and spacing checker
    // ========================================
    always @(negedge clk) begin
        if (rstN) begin
            cycleCount++;
            if (dqmBitEn) begin
                if (expQ.size() == 0) begin
                    errors++;
                    $display("a bit strobe came while no frame bit was expected");
                end else begin
                    expBit = expQ.pop_front();
                    checks++;
                    if (dqmBit !== expBit) begin
                        reportMismatch($sformatf("frame %0d bit %0d", frameCount, bitIdx),
                                       expBit, dqmBit);
                    end
                end
                // the first bit of a frame has no fixed distance to the one before
                if (bitIdx > 0) begin
                    checks++;
                    if (cycleCount - lastBitCycle != curCpb) begin
                        reportMismatch("bit spacing", curCpb, cycleCount - lastBitCycle);
                    end
                end
                lastBitCycle = cycleCount;
                bitIdx++;
            end
            if (dqmStartOfFrame) begin
                frameRef(expDqm, curPayload);
                frameCount++;
                bitIdx = 0;
            end
        end
    end

    initial begin
        logic [31:0] rd;
        int          dropsBefore;
        int          framesBefore;
        clk          = 1'b0;
        rstN         = 1'b0;
        cs           = 1'b0;
        wr           = 1'b0;
        addr         = '0;
        wdata        = '0;
        magClkEn     = 1'b0;
        mag          = '0;
        bitClkEn     = 1'b0;
        payloadBit   = 1'b0;
        rng          = 32'd80;
        errors       = 0;
        checks       = 0;
        frameCount   = 0;
        bitIdx       = 0;
        cycleCount   = 0;
        lastBitCycle = 0;
        curCpb       = 4;
        curPayload   = 0;
        expDqm       = '0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;

        // ========================================
        // register and LUT access
        // ========================================
        busRead(CTRL_ADDR, rd);
        checks++;
        if (rd !== 32'd0) reportMismatch("ctrl after reset", 0, rd);
        busRead(MEAN_ADDR, rd);
        checks++;
        if (rd !== 32'd0) reportMismatch("mean after reset", 0, rd);
        busRead(BITTIME_ADDR, rd);
        checks++;
        if (rd !== 32'd4) reportMismatch("bittime after reset", 4, rd);

        busWrite(CTRL_ADDR, 32'h2ABC_0005);
        busWrite(MEAN_ADDR, 32'h0000_1234);
        busWrite(BITTIME_ADDR, 32'h0000_BEEF);
        busRead(CTRL_ADDR, rd);
        checks++;
        if (rd !== 32'h2ABC_0005) reportMismatch("ctrl readback", 32'h2ABC_0005, rd);
        busRead(MEAN_ADDR, rd);
        checks++;
        if (rd !== 32'h0000_1234) reportMismatch("mean readback", 32'h1234, rd);
        busRead(BITTIME_ADDR, rd);
        checks++;
        if (rd !== 32'h0000_BEEF) reportMismatch("bittime readback", 32'hBEEF, rd);

        for (int i = 0; i < 64; i++) begin
            rng         = xorshift32(rng);
            lutModel[i] = rng[15:0];
            busWrite(8'(LUT_BASE + 8'(i)), {16'h0000, lutModel[i]});
        end
        for (int i = 0; i < 64; i++) begin
            busRead(8'(LUT_BASE + 8'(i)), rd);
            checks++;
            if (rd !== {16'h0000, lutModel[i]}) begin
                reportMismatch($sformatf("lut word %0d", i), lutModel[i], rd);
            end
        end

        // ========================================
        // single frames at two bit times
        // ========================================
        busWrite(MEAN_ADDR, 32'(MEAN_VALUE));
        busWrite(BITTIME_ADDR, 32'd4);
        curCpb = 4;
        runFrameTest("small spread", 3, 8, 3, 8);
        runFrameTest("medium spread", 3, 8, 40, 8);
        busWrite(BITTIME_ADDR, 32'd7);
        curCpb = 7;
        runFrameTest("fifo underrun", 4, 6, 200, 3);
        runFrameTest("saturated index", 2, 5, 2000, 10);
        runFrameTest("leftover payload", 0, 5, 1, 0);

        // ========================================
        // blocks arriving while the framer is busy
        // ========================================
        busRead(STATUS_ADDR, rd);
        dropsBefore  = int'(rd[15:8]);
        framesBefore = frameCount;
        busWrite(CTRL_ADDR, {2'b00, 14'd4, 12'h000, 4'd1});
        curPayload = 4;
        // zero spread keeps every block at index 0, whichever ones get through
        expDqm = lutModel[0];
        for (int i = 0; i < 16; i++) begin
            driveBlock(1, 0);
        end
        waitQuiet();
        busRead(STATUS_ADDR, rd);
        checks++;
        if (int'(rd[15:8]) <= dropsBefore) begin
            errors++;
            $display("the dropped count did not grow while the framer was busy");
        end
        checks++;
        if (rd[5:0] !== 6'd0) reportMismatch("status log index", 0, rd[5:0]);
        checks++;
        if (frameCount - framesBefore < 2) begin
            errors++;
            $display("fewer than two frames were sent for the busy burst");
        end

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
common/dqmConfigPkg.sv
common/dqmFramePkg.sv
common/dqmBusIf.sv
common/dqmEstimateIf.sv
logic/dqmRegs.sv
mseEstimate/mseEstimate.sv
logic/dqmLookupTable.sv
dqmFramer/dqmFramer.sv
logic/dqm.sv
bench/dqmTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f --top-module dqmTb -o dqmSim

simOutput=$(./obj_dir/dqmSim)
echo "$simOutput"

if echo "$simOutput" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
